/* common/vcfg_pkg.sv */
// shared types and constants for the vector configuration path
// covers vsetvli, vsetivli and vsetvl plus the shadow / queue / arch stages
// every block refers to these by scoped names

package vcfg_pkg;

    localparam int VLEN   = 128;              // vector register length in bits
    localparam int QDEPTH = 4;                // in-flight queue depth
    localparam int QPTR_W = $clog2(QDEPTH);   // queue pointer width
    localparam int QCNT_W = $clog2(QDEPTH + 1);

    localparam logic [6:0] OPC_OPV   = 7'b1010111;  // OP-V major opcode
    localparam logic [2:0] F3_OPCFG  = 3'b111;      // config group of OP-V
    localparam logic [1:0] FORM_IVLI = 2'b11;       // vsetivli tag in [31:30]
    localparam logic [1:0] FORM_VL   = 2'b10;       // vsetvl tag in [31:30]

    typedef logic [31:0] vl_t;

    // element width codes above SEW32 are unsupported
    typedef enum logic [2:0] {
        SEW8  = 3'b000,
        SEW16 = 3'b001,
        SEW32 = 3'b010
    } vsew_t;

    typedef enum logic [2:0] {
        LMUL1      = 3'b000,
        LMUL2      = 3'b001,
        LMUL4      = 3'b010,
        LMUL8      = 3'b011,
        LMULRSVD   = 3'b100,  // reserved encoding
        LMULEIGHTH = 3'b101,
        LMULFOURTH = 3'b110,
        LMULHALF   = 3'b111
    } vlmul_t;

    // vtype CSR low byte order with vill on top
    typedef struct packed {
        logic   vill;
        logic   vma;
        logic   vta;
        vsew_t  vsew;
        vlmul_t vlmul;
    } vtype_t;

    typedef enum logic [1:0] {
        VSETVLI  = 2'd0,
        VSETIVLI = 2'd1,
        VSETVL   = 2'd2,
        NOT_VCFG = 2'd3
    } vcfg_kind_t;

    // vsetvli / vsetvl layout
    typedef struct packed {
        logic        top;     // 0 = vsetvli, 1 = vsetvl or vsetivli
        logic [10:0] zimm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } vcfg_reg_view_t;

    // vsetivli layout
    typedef struct packed {
        logic [1:0] form;
        logic [9:0] zimm;
        logic [4:0] uimm;     // avl immediate
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vcfg_imm_view_t;

    typedef union packed {
        vcfg_reg_view_t r;
        vcfg_imm_view_t i;
    } vcfg_inst_u;

    typedef struct packed {
        vcfg_inst_u  inst;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
    } vcfg_req_t;

    typedef struct packed {
        vcfg_kind_t kind;
        vtype_t     vtype_req;
        vl_t        avl;
        logic [4:0] rd;
        logic       keep_vl;    // rs1 = x0, rd = x0
        logic       vlmax_req;  // rs1 = x0, rd != x0
    } vcfg_dec_t;

    typedef struct packed {
        vtype_t     vtype;
        vl_t        vl;
        logic [4:0] rd;
        logic       wr_rd;      // rd is not x0
    } vcfg_entry_t;

endpackage

/* design/vcfg_arch_csr.sv */
// architectural vtype / vl / vill, committed from the queue head
// a retire pulse pops one entry, vl goes back to rd a cycle later

`timescale 1ns/1ps

module vcfg_arch_csr (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  retire,
    input  logic                  flush,
    input  vcfg_pkg::vcfg_entry_t head,
    input  logic                  not_empty,
    output logic                  pop,
    output vcfg_pkg::vtype_t      arch_vtype,
    output vcfg_pkg::vl_t         arch_vl,
    output logic                  rd_wr_valid,
    output logic [4:0]            rd_idx,
    output vcfg_pkg::vl_t         rd_data
);

    logic do_wb;

    // flush wins over retire
    assign pop   = retire && not_empty && !flush;
    assign do_wb = pop && head.wr_rd;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            arch_vtype  <= '{vill: 1'b0, vma: 1'b0, vta: 1'b0,
                             vsew: vcfg_pkg::SEW8, vlmul: vcfg_pkg::LMUL1};
            arch_vl     <= '0;
            rd_wr_valid <= 1'b0;
        end else begin
            rd_wr_valid <= do_wb;       // single cycle pulse
            if (pop) begin
                arch_vtype <= head.vtype;  // vill kept here only
                arch_vl    <= head.vl;
            end
        end
    end

    // writeback payload
    always_ff @(posedge CLK) begin
        if (do_wb) begin
            rd_idx  <= head.rd;
            rd_data <= head.vl;
        end
    end

endmodule

/* design/vcfg_decode.sv */
// combinational decode of the vector configuration instructions
// classifies the word, picks the vtype source and the avl source
// and flags the rs1 = x0 special cases for the shadow stage

`timescale 1ns/1ps

module vcfg_decode (
    input  vcfg_pkg::vcfg_req_t req,
    output vcfg_pkg::vcfg_dec_t dec
);

    vcfg_pkg::vcfg_inst_u inst;
    logic                 is_cfg;   // OP-V with the config funct3
    logic                 rs1_x0;
    logic                 rd_x0;
    logic [7:0]           vt_bits;  // vma, vta, vsew, vlmul

    assign inst   = req.inst;
    assign is_cfg = (inst.r.opcode == vcfg_pkg::OPC_OPV) &&
                    (inst.r.funct3 == vcfg_pkg::F3_OPCFG);
    assign rs1_x0 = (inst.r.rs1 == 5'd0);
    assign rd_x0  = (inst.r.rd == 5'd0);

    always_comb begin
        dec           = '0;
        dec.kind      = vcfg_pkg::NOT_VCFG;
        dec.rd        = inst.r.rd;
        vt_bits       = '0;
        if (is_cfg) begin
            if (!inst.r.top) begin
                dec.kind = vcfg_pkg::VSETVLI;
                vt_bits  = inst.r.zimm[7:0];    // upper zimm bits ignored
            end else if (inst.i.form == vcfg_pkg::FORM_IVLI) begin
                dec.kind = vcfg_pkg::VSETIVLI;
                vt_bits  = inst.i.zimm[7:0];
            end else if (inst.i.form == vcfg_pkg::FORM_VL) begin
                dec.kind = vcfg_pkg::VSETVL;
                vt_bits  = req.rs2_val[7:0];    // vtype from rs2
            end
        end

        dec.vtype_req = {1'b0, vt_bits};  // vill never requested

        case (dec.kind)
            vcfg_pkg::VSETVLI, vcfg_pkg::VSETVL: begin
                dec.avl       = req.rs1_val;
                dec.keep_vl   = rs1_x0 && rd_x0;
                dec.vlmax_req = rs1_x0 && !rd_x0;
            end
            vcfg_pkg::VSETIVLI: begin
                // uimm sits where rs1 would be
                dec.avl = {27'd0, inst.i.uimm};
            end
            default: begin
                dec.rd = 5'd0;  // nothing to write back
            end
        endcase
    end

endmodule

/* design/vcfg_top.sv */
// top of the vector configuration path
// decode + shadow produce configs, the queue holds them, arch commits
// requests use valid/ready, retire and flush are single-cycle pulses

`timescale 1ns/1ps

module vcfg_top (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                req_valid,
    input  vcfg_pkg::vcfg_req_t req,
    input  logic                retire,
    input  logic                flush,
    output logic                req_ready,
    output vcfg_pkg::vtype_t    vtype_shadow,
    output vcfg_pkg::vl_t       vl_shadow,
    output vcfg_pkg::vtype_t    arch_vtype,
    output vcfg_pkg::vl_t       arch_vl,
    output logic                rd_wr_valid,
    output logic [4:0]          rd_idx,
    output vcfg_pkg::vl_t       rd_data
);

    vcfg_pkg::vcfg_dec_t   dec;
    vcfg_pkg::vcfg_entry_t new_cfg;
    vcfg_pkg::vcfg_entry_t head;
    logic                  accept;
    logic                  push, pop;
    logic                  not_empty, full;

    assign req_ready = !full;  // registered queue state only
    assign accept    = req_valid && req_ready;

    vcfg_decode i_decode (
        .req (req),
        .dec (dec)
    );

    vcfg_shadow_csr i_shadow (
        .CLK          (CLK),
        .nRST         (nRST),
        .dec          (dec),
        .accept       (accept),
        .flush        (flush),
        .arch_vtype   (arch_vtype),
        .arch_vl      (arch_vl),
        .vtype_shadow (vtype_shadow),
        .vl_shadow    (vl_shadow),
        .new_cfg      (new_cfg),
        .push         (push)
    );

    vcfg_inflight_fifo i_fifo (
        .CLK       (CLK),
        .nRST      (nRST),
        .push      (push),
        .wdata     (new_cfg),
        .pop       (pop),
        .flush     (flush),
        .head      (head),
        .not_empty (not_empty),
        .full      (full)
    );

    vcfg_arch_csr i_arch (
        .CLK         (CLK),
        .nRST        (nRST),
        .retire      (retire),
        .flush       (flush),
        .head        (head),
        .not_empty   (not_empty),
        .pop         (pop),
        .arch_vtype  (arch_vtype),
        .arch_vl     (arch_vl),
        .rd_wr_valid (rd_wr_valid),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data)
    );

endmodule

/* dv/vcfg_model.svh */
// reference model of the vector configuration path for the testbench module
// predict_edge runs once per rising edge on the inputs the DUT saw at that edge

`ifndef VCFG_MODEL_SVH
`define VCFG_MODEL_SVH

    logic [2:0]            m_sew, m_lmul;   // shadow vtype fields
    logic [31:0]           m_vl;
    vcfg_pkg::vtype_t      m_arch_vtype;
    logic [31:0]           m_arch_vl;
    vcfg_pkg::vcfg_entry_t m_q[$];          // in flight entries oldest first
    logic                  m_wr;            // rd write expected this cycle
    logic [4:0]            m_rd_idx;
    logic [31:0]           m_rd_data;

    task automatic clear_model();
        m_sew        = '0;
        m_lmul       = '0;
        m_vl         = '0;
        m_arch_vtype = '0;
        m_arch_vl    = '0;
        m_wr         = 1'b0;
        m_q.delete();
    endtask

    // elements in one register group for a legal sew and lmul
    function automatic logic [31:0] calc_vlmax(input logic [2:0] sew, input logic [2:0] lmul);
        logic [31:0] per_reg;
        per_reg = vcfg_pkg::VLEN / (8 << sew);
        return lmul[2] ? per_reg >> (4'd8 - lmul) : per_reg << lmul;  // fractional or not
    endfunction

    task automatic predict_edge(input logic v, input vcfg_pkg::vcfg_req_t r,
                                input logic ret, input logic fl);
        logic [31:0]           w;
        logic [7:0]            vt;
        logic [31:0]           vlmax;
        logic [31:0]           avl;
        logic                  acc;
        vcfg_pkg::vcfg_entry_t e;
        w    = r.inst;
        acc  = v && (m_q.size() < vcfg_pkg::QDEPTH);   // ready from the count before the edge
        m_wr = 1'b0;
        if (fl) begin
            m_sew  = m_arch_vtype.vsew;  // shadow rebuilt from committed state
            m_lmul = m_arch_vtype.vlmul;
            m_vl   = m_arch_vl;
            m_q.delete();
            return;
        end
        if (ret && m_q.size() > 0) begin
            e            = m_q.pop_front();
            m_arch_vtype = e.vtype;
            m_arch_vl    = e.vl;
            m_wr         = e.wr_rd;
            m_rd_idx     = e.rd;
            m_rd_data    = e.vl;
        end
        if (!acc || w[6:0] != 7'h57 || w[14:12] != 3'b111)
            return;  // idle or not a vset* word
        vt      = (w[31:30] == 2'b10) ? r.rs2_val[7:0] : w[27:20];  // vsetvl reads rs2
        e.rd    = w[11:7];
        e.wr_rd = (w[11:7] != 5'd0);
        if (vt[5:3] > 3'd2 || vt[7:6] != 2'b00 || vt[2:0] == 3'b100) begin
            e.vtype = 9'h100;  // only vill set
            e.vl    = '0;
        end else begin
            vlmax   = calc_vlmax(vt[5:3], vt[2:0]);
            e.vtype = {1'b0, vt};
            if (w[31:30] == 2'b11)
                avl = {27'd0, w[19:15]};   // vsetivli uimm
            else if (w[19:15] != 5'd0)
                avl = r.rs1_val;
            else
                avl = vlmax;               // rd not x0 asks for vlmax
            e.vl = (avl < vlmax) ? avl : vlmax;
            if (w[31:30] != 2'b11 && w[19:15] == 5'd0 && w[11:7] == 5'd0)
                e.vl = m_vl;               // rs1 = rd = x0 keeps vl
        end
        m_sew  = e.vtype.vsew;
        m_lmul = e.vtype.vlmul;
        m_vl   = e.vl;
        m_q.push_back(e);
    endtask

`endif

/* dv/vcfg_tb.sv */
// testbench for the vector configuration path
// seeded random vset* traffic with random retire and flush pulses
// every output is compared each cycle against the included model

`timescale 1ns/1ps

module vcfg_tb;

    logic                CLK, nRST;
    logic                req_valid, retire, flush;
    vcfg_pkg::vcfg_req_t req;
    logic                req_ready, rd_wr_valid;
    vcfg_pkg::vtype_t    vtype_shadow, arch_vtype;
    vcfg_pkg::vl_t       vl_shadow, arch_vl, rd_data;
    logic [4:0]          rd_idx;
    integer              seed = 86;
    int                  checks = 0;
    int                  errors = 0;

`include "vcfg_model.svh"

    vcfg_top i_dut (.*);

    always #2 CLK = ~CLK;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_outputs();
        compare_value("req_ready", m_q.size() < vcfg_pkg::QDEPTH, req_ready);
        compare_value("vtype_shadow", {m_sew, m_lmul}, vtype_shadow);  // vill never shown
        compare_value("vl_shadow", m_vl, vl_shadow);
        compare_value("arch_vtype", m_arch_vtype, arch_vtype);
        compare_value("arch_vl", m_arch_vl, arch_vl);
        compare_value("rd_wr_valid", m_wr, rd_wr_valid);
        if (m_wr) begin
            compare_value("rd_idx", m_rd_idx, rd_idx);  // payload only valid with the pulse
            compare_value("rd_data", m_rd_data, rd_data);
        end
    endtask

    // model sees the old inputs and new ones land on the same edge
    task automatic step_cycle(input logic v, input vcfg_pkg::vcfg_req_t r,
                              input logic ret, input logic fl);
        @(posedge CLK);
        predict_edge(req_valid, req, retire, flush);
        req_valid <= v;
        req       <= r;
        retire    <= ret;
        flush     <= fl;
        @(negedge CLK);
        check_outputs();
    endtask

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // form 0 vsetvli, 1 vsetivli (src is uimm), 2 vsetvl with vtype in rs2
    function automatic vcfg_pkg::vcfg_req_t make_req(input int form, input logic [4:0] rd,
            input logic [4:0] src, input logic [7:0] vt, input logic [31:0] avl);
        logic [31:0] w;
        case (form)
            0:       w = {1'b0, 3'b000, vt, src, 3'b111, rd, 7'h57};
            1:       w = {2'b11, 2'b00, vt, src, 3'b111, rd, 7'h57};
            default: w = {7'b1000000, 5'd2, src, 3'b111, rd, 7'h57};
        endcase
        return {w, avl, (form == 2) ? {24'd0, vt} : 32'd0};
    endfunction

    function automatic logic [7:0] pick_vtype(input logic illegal);
        logic [7:0] vt;
        vt = {2'b00, 3'(rnd(3)), 3'(rnd(7))};
        if (vt[2:0] >= 3'd4)
            vt[2:0] = vt[2:0] + 3'd1;  // skip reserved lmul
        if (illegal) begin
            case (rnd(3))
                0:       vt[5:3] = 3'(3 + rnd(5));  // sew above 32
                1:       vt[7:6] = 2'(1 + rnd(3));  // vta and/or vma
                default: vt[2:0] = 3'b100;
            endcase
        end
        return vt;
    endfunction

    // kind 0 legal, 1 illegal vtype, 2 rs1 = x0, 3 not a config word
    function automatic vcfg_pkg::vcfg_req_t pick_req(input int kind);
        vcfg_pkg::vcfg_req_t r;
        logic [31:0]         avl;
        avl = rnd(2) ? rnd(64) : $random(seed);  // mostly small, some huge
        r   = make_req(rnd(3), 5'(rnd(32)), 5'(1 + rnd(31)), pick_vtype(kind == 1), avl);
        if (kind == 2)
            r = make_req(2 * rnd(2), 5'(rnd(2) * rnd(32)), 5'd0, pick_vtype(1'b0), avl);
        if (kind == 3) begin
            r = {$random(seed), $random(seed), $random(seed)};
            if (rnd(2))
                r.inst.r.opcode = 7'h57;   // OP-V but another funct3
            r.inst.r.funct3 = 3'(rnd(7));  // never the config group
        end
        return r;
    endfunction

    // valid held until ready so acceptance lands on the next step
    task automatic send(input vcfg_pkg::vcfg_req_t r, input int ret_pct);
        int waited;
        waited = 0;
        step_cycle(1'b1, r, rnd(100) < ret_pct, 1'b0);
        while (!req_ready && waited < 40) begin
            step_cycle(1'b1, r, rnd(100) < ret_pct, 1'b0);
            waited++;
        end
        if (!req_ready) begin
            errors++;
            $display("timeout: req_ready stayed low for %0d cycles", waited);
        end
    endtask

    // one retire pulse per queue slot empties even a full queue
    task automatic drain();
        repeat (vcfg_pkg::QDEPTH)
            step_cycle(1'b0, '0, 1'b1, 1'b0);
        step_cycle(1'b0, '0, 1'b0, 1'b0);  // last rd write shows here
    endtask

    task automatic random_traffic(input string name, input int kind, input int n,
                                  input int ret_pct, input int fl_pct);
        int err_start;
        err_start = errors;
        repeat (n) begin
            send(pick_req(kind), ret_pct);
            if (rnd(100) < fl_pct)
                step_cycle(1'b1, pick_req(0), 1'b1, 1'b1);  // request and retire get dropped
            else if (rnd(4) == 0)
                step_cycle(1'b0, '0, rnd(100) < ret_pct, 1'b0);
        end
        drain();
        if (kind == 1) begin
            compare_value("arch_vtype", 32'h100, arch_vtype);  // vill with zero fields
            compare_value("arch_vl", 32'h0, arch_vl);
        end
        $display("%s: done, %0d errors", name, errors - err_start);
    endtask

    initial begin
        CLK       = 1'b0;
        nRST      = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        retire    = 1'b0;
        flush     = 1'b0;
        clear_model();
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_outputs();  // reset values
        random_traffic("legal", 0, 40, 20, 0);
        random_traffic("illegal", 1, 20, 20, 0);
        random_traffic("x0", 2, 30, 20, 0);
        random_traffic("in-order", 0, 60, 25, 0);  // back to back so the queue fills
        random_traffic("flush", 0, 40, 30, 30);
        random_traffic("non-config", 3, 20, 0, 0);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* shadow_csr/vcfg_inflight_fifo.sv */
// circular queue of computed configurations waiting for retirement
// push and pop may share a cycle and a flush drops every entry

`timescale 1ns/1ps

module vcfg_inflight_fifo (
    input  logic                  CLK,
    input  logic                  nRST,
    input  logic                  push,
    input  vcfg_pkg::vcfg_entry_t wdata,
    input  logic                  pop,
    input  logic                  flush,
    output vcfg_pkg::vcfg_entry_t head,
    output logic                  not_empty,
    output logic                  full
);

    vcfg_pkg::vcfg_entry_t         mem [vcfg_pkg::QDEPTH];
    logic [vcfg_pkg::QPTR_W-1:0]   wptr, rptr;
    logic [vcfg_pkg::QCNT_W-1:0]   count;
    logic                          do_push, do_pop;

    assign full      = (count == vcfg_pkg::QCNT_W'(vcfg_pkg::QDEPTH));
    assign not_empty = (count != '0);
    assign do_push   = push && !full && !flush;
    assign do_pop    = pop && not_empty && !flush;
    assign head      = mem[rptr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (flush) begin
            wptr  <= '0;  // everything in flight is discarded
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_push)
                wptr <= wptr + 1'b1;  // wraps at QDEPTH
            if (do_pop)
                rptr <= rptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // both or neither
            endcase
        end
    end

    // entry storage
    always_ff @(posedge CLK) begin
        if (do_push)
            mem[wptr] <= wdata;
    end

endmodule

/* shadow_csr/vcfg_shadow_csr.sv */
// speculative vtype / vl copy seen by decode
// computes the new configuration for each accepted vset* instruction,
// pushes it toward the in-flight queue and reloads from arch on flush
// vill is kept out of the speculative view

`timescale 1ns/1ps

module vcfg_shadow_csr (
    input  logic                  CLK,
    input  logic                  nRST,
    input  vcfg_pkg::vcfg_dec_t   dec,
    input  logic                  accept,
    input  logic                  flush,
    input  vcfg_pkg::vtype_t      arch_vtype,
    input  vcfg_pkg::vl_t         arch_vl,
    output vcfg_pkg::vtype_t      vtype_shadow,
    output vcfg_pkg::vl_t         vl_shadow,
    output vcfg_pkg::vcfg_entry_t new_cfg,
    output logic                  push
);

    vcfg_pkg::vsew_t  vsew_q, vsew_next;
    vcfg_pkg::vlmul_t vlmul_q, vlmul_next;
    vcfg_pkg::vl_t    vl_q, vl_next;
    vcfg_pkg::vl_t    sew_base;   // VLEN / SEW
    vcfg_pkg::vl_t    vlmax;
    logic             illegal;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            vsew_q  <= vcfg_pkg::SEW8;
            vlmul_q <= vcfg_pkg::LMUL1;
            vl_q    <= '0;
        end else begin
            vsew_q  <= vsew_next;
            vlmul_q <= vlmul_next;
            vl_q    <= vl_next;
        end
    end

    assign vtype_shadow = '{vill: 1'b0, vma: 1'b0, vta: 1'b0, vsew: vsew_q, vlmul: vlmul_q};
    assign vl_shadow    = vl_q;

    // vlmax = VLEN / SEW * LMUL
    always_comb begin
        case (dec.vtype_req.vsew)
            vcfg_pkg::SEW8:  sew_base = vcfg_pkg::VLEN / 8;
            vcfg_pkg::SEW16: sew_base = vcfg_pkg::VLEN / 16;
            vcfg_pkg::SEW32: sew_base = vcfg_pkg::VLEN / 32;
            default:         sew_base = '0;  // unsupported width
        endcase
        case (dec.vtype_req.vlmul)
            vcfg_pkg::LMUL1:      vlmax = sew_base;
            vcfg_pkg::LMUL2:      vlmax = sew_base << 1;
            vcfg_pkg::LMUL4:      vlmax = sew_base << 2;
            vcfg_pkg::LMUL8:      vlmax = sew_base << 3;
            vcfg_pkg::LMULHALF:   vlmax = sew_base >> 1;
            vcfg_pkg::LMULFOURTH: vlmax = sew_base >> 2;
            vcfg_pkg::LMULEIGHTH: vlmax = sew_base >> 3;  // may round to 0
            default:              vlmax = '0;
        endcase
    end

    // only tail / mask undisturbed supported
    assign illegal = (dec.vtype_req.vsew > vcfg_pkg::SEW32) ||
                     dec.vtype_req.vta || dec.vtype_req.vma ||
                     (dec.vtype_req.vlmul == vcfg_pkg::LMULRSVD);

    always_comb begin
        new_cfg.rd    = dec.rd;
        new_cfg.wr_rd = (dec.rd != 5'd0);
        if (illegal) begin
            new_cfg.vtype = '{vill: 1'b1, vma: 1'b0, vta: 1'b0,
                              vsew: vcfg_pkg::SEW8, vlmul: vcfg_pkg::LMUL1};
            new_cfg.vl    = '0;
        end else begin
            new_cfg.vtype = dec.vtype_req;
            if (dec.keep_vl)
                new_cfg.vl = vl_q;          // rs1 = rd = x0
            else if (dec.vlmax_req)
                new_cfg.vl = vlmax;
            else if (dec.avl < vlmax)
                new_cfg.vl = dec.avl;
            else
                new_cfg.vl = vlmax;         // clamp
        end
    end

    assign push = accept && !flush && (dec.kind != vcfg_pkg::NOT_VCFG);

    always_comb begin
        vsew_next  = vsew_q;
        vlmul_next = vlmul_q;
        vl_next    = vl_q;
        if (flush) begin
            // rebuild from committed state
            vsew_next  = arch_vtype.vsew;
            vlmul_next = arch_vtype.vlmul;
            vl_next    = arch_vl;
        end else if (push) begin
            vsew_next  = new_cfg.vtype.vsew;   // zeroed when illegal
            vlmul_next = new_cfg.vtype.vlmul;
            vl_next    = new_cfg.vl;
        end
    end

endmodule

/* sim.f */
+incdir+dv
common/vcfg_pkg.sv
design/vcfg_decode.sv
shadow_csr/vcfg_shadow_csr.sv
shadow_csr/vcfg_inflight_fifo.sv
design/vcfg_arch_csr.sv
design/vcfg_top.sv
dv/vcfg_tb.sv
